// File: bench/tetris_scoring_stimulus.dat
// Columns: id op valid lines spin new_game falling tick score(BCD) level total(hex) ticks(hex)
// op 0 runs one clock, op 1 ticks until drop_due, op 2 ticks with falling low
// Single clears at level 0
01_0_0_0_0_1_0_0_00000000_0_00_00
01_0_1_1_0_0_0_0_00000040_0_01_00
01_0_0_0_0_1_0_0_00000000_0_00_00
01_0_1_4_0_0_0_0_00001200_0_04_00
01_0_0_0_0_0_0_0_00001200_0_04_00
// Streak bonus, capped at 500, broken by an empty T-spin lock
02_0_0_0_0_1_0_0_00000000_0_00_00
02_0_1_1_0_0_0_0_00000040_0_01_00
02_0_1_1_0_0_0_0_00000180_0_02_00
02_0_1_1_0_0_0_0_00000420_0_03_00
02_0_1_1_0_0_0_0_00000760_0_04_00
02_0_1_1_0_0_0_0_00001200_0_05_00
02_0_1_1_0_0_0_0_00001740_0_06_00
02_0_1_1_0_0_0_0_00002280_0_07_00
02_0_1_0_1_0_0_0_00002280_0_07_00
02_0_1_1_0_0_0_0_00002320_0_08_00
// Level steps at 10 and 20 lines
03_0_0_0_0_1_0_0_00000000_0_00_00
03_0_1_4_0_0_0_0_00001200_0_04_00
03_0_1_4_0_0_0_0_00002500_0_08_00
03_0_1_2_0_0_0_0_00002800_1_0a_00
03_0_1_1_0_0_0_0_00003180_1_0b_00
03_0_1_4_0_0_0_0_00005980_1_0f_00
03_0_1_4_0_0_0_0_00008880_1_13_00
03_0_1_1_0_0_0_0_00009460_2_14_00
03_0_1_4_0_0_0_0_00013560_2_18_00
// Spin awards
04_0_0_0_0_1_0_0_00000000_0_00_00
04_0_1_2_1_0_0_0_00001300_0_02_00
04_0_1_0_0_0_0_0_00001300_0_02_00
04_0_1_1_2_0_0_0_00001540_0_03_00
04_0_1_0_2_0_0_0_00001540_0_03_00
04_0_1_4_5_0_0_0_00004340_0_07_00
04_0_1_3_3_0_0_0_00005940_1_0a_00
04_0_1_3_1_0_0_0_00009940_1_0d_00
04_0_1_4_5_0_0_0_00015840_1_11_00
// Gravity at level 0 and level 1
05_0_0_0_0_1_0_0_00000000_0_00_00
05_1_0_0_0_0_1_1_00000000_0_00_29
05_2_0_0_0_0_0_1_00000000_0_00_3c
05_0_1_4_0_0_0_0_00001200_0_04_00
05_0_1_4_0_0_0_0_00002500_0_08_00
05_0_1_4_0_0_0_0_00003900_1_0c_00
05_1_0_0_0_0_1_1_00003900_1_0c_26
// New game wins over a lock in the same cycle
06_0_1_4_0_1_0_0_00000000_0_00_00
06_0_1_1_0_0_0_0_00000040_0_01_00

// File: tetris_scoring.f
src/tetris_score_pkg.sv
src/tetris_pace_pkg.sv
src/clear_event_if.sv
src/level_tracker.sv
src/line_award.sv
src/spin_award.sv
src/score_accumulator.sv
src/tetris_scoring.sv
bench/tb_tetris_scoring.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scoring testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tetris_scoring.f \
  --top-module tb_tetris_scoring \
  -o tb_tetris_scoring

out=$(./obj_dir/tb_tetris_scoring)
echo "$out"

if echo "$out" | grep -q "^Result: PASSED$"; then
  exit 0
else
  exit 1
fi

// File: bench/tb_tetris_scoring.sv
module tb_tetris_scoring;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int STIM_W     = 88;   // Packed width of one stimulus entry
  localparam int STIM_MAX   = 128;
  localparam int DROP_LIMIT = 64;   // Ticks before a missing drop counts as lost

  logic                         clk;
  logic                         rst;
  logic                         tick_game;
  logic                         new_game;
  logic                         clear_valid;
  logic [2:0]                   clear_lines;
  tetris_score_pkg::spin_kind_t clear_spin;
  logic                         falling;
  logic [31:0]                  score;
  logic [3:0]                   level;
  logic [7:0]                   total_lines;
  logic                         drop_due;

  logic [STIM_W-1:0] stim [STIM_MAX];
  int                n_steps;
  bit                loaded;
  int                pass_count;
  int                fail_count;
  int                test_errors;

  tetris_scoring #(
    .LINES_PER_LEVEL(10),
    .SCORE_DIGITS(8)
  ) tetris_scoring_inst (
    .clk         (clk),
    .rst         (rst),
    .tick_game   (tick_game),
    .new_game    (new_game),
    .clear_valid (clear_valid),
    .clear_lines (clear_lines),
    .clear_spin  (clear_spin),
    .falling     (falling),
    .score       (score),
    .level       (level),
    .total_lines (total_lines),
    .drop_due    (drop_due)
  );

  always #50 clk = ~clk;  // 100 ns period

  // ====================================================================
  // Checks and reporting
  // ====================================================================

  task automatic compare_outputs(input logic [31:0] exp_score, input logic [3:0] exp_level,
                                 input logic [7:0] exp_total);
    assert (score === exp_score) else begin
      $display("FAILED at %0d ns: score %h, expected %h", $time, score, exp_score);
      test_errors++;
    end
    assert (level === exp_level) else begin
      $display("FAILED at %0d ns: level %0d, expected %0d", $time, level, exp_level);
      test_errors++;
    end
    assert (total_lines === exp_total) else begin
      $display("FAILED at %0d ns: total_lines %0d, expected %0d", $time, total_lines, exp_total);
      test_errors++;
    end
  endtask

  // Ticks every cycle until drop_due shows up
  task automatic wait_for_drop(input logic [7:0] exp_ticks);
    int ticks;
    ticks     = 0;
    tick_game = 1'b1;
    do begin
      @(posedge clk);
      #5;
      ticks++;
    end while (!drop_due && ticks < DROP_LIMIT);
    tick_game = 1'b0;
    falling   = 1'b0;
    assert (drop_due) else begin
      $display("FAILED at %0d ns: drop_due did not fire within %0d ticks", $time, DROP_LIMIT);
      test_errors++;
    end
    if (drop_due) begin
      assert (ticks == int'(exp_ticks)) else begin
        $display("FAILED at %0d ns: drop_due after %0d ticks, expected %0d",
                 $time, ticks, exp_ticks);
        test_errors++;
      end
    end
  endtask

  task automatic hold_no_drop(input logic [7:0] n_ticks);
    falling   = 1'b0;
    tick_game = 1'b1;
    repeat (n_ticks) begin
      @(posedge clk);
      #5;
      assert (!drop_due) else begin
        $display("FAILED at %0d ns: drop_due fired with falling low", $time);
        test_errors++;
      end
    end
    tick_game = 1'b0;
  endtask

  task automatic report_test(input logic [7:0] id);
    if (test_errors == 0) begin
      pass_count++;
      $display("Test %0d: passed", id);
    end else begin
      fail_count++;
      $display("Test %0d: failed with %0d errors", id, test_errors);
    end
    test_errors = 0;
  endtask

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial begin
    logic [7:0]  id;
    logic [7:0]  cur_id;
    logic [3:0]  op, f_valid, f_lines, f_spin, f_new, f_fall, f_tick, exp_level;
    logic [31:0] exp_score;
    logic [7:0]  exp_total;
    logic [7:0]  exp_ticks;
    clk         = 1'b0;
    rst         = 1'b1;
    tick_game   = 1'b0;
    new_game    = 1'b0;
    clear_valid = 1'b0;
    clear_lines = '0;
    clear_spin  = tetris_score_pkg::SPIN_NONE;
    falling     = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;

    // Unused slots carry an end marker in the id field
    for (int i = 0; i < STIM_MAX; i++) begin
      stim[i] = {8'hff, (STIM_W - 8)'(i)};
    end
    $readmemh("bench/tetris_scoring_stimulus.dat", stim);
    n_steps = 0;
    while (n_steps < STIM_MAX && stim[n_steps][STIM_W-1 -: 8] != 8'hff) begin
      n_steps++;
    end
    loaded = 1'b1;
    if (n_steps == 0) begin
      $display("No stimulus entries could be read from the data file");
      fail_count++;
    end

    repeat (5) @(posedge clk);
    #5;
    rst = 1'b0;

    // Test 0 is the state right after reset
    compare_outputs(32'h0, 4'd0, 8'd0);
    assert (!drop_due) else begin
      $display("FAILED at %0d ns: drop_due high after reset", $time);
      test_errors++;
    end
    report_test(8'd0);

    cur_id = stim[0][STIM_W-1 -: 8];
    for (int i = 0; i < n_steps; i++) begin
      {id, op, f_valid, f_lines, f_spin, f_new, f_fall, f_tick,
       exp_score, exp_level, exp_total, exp_ticks} = stim[i];
      if (id != cur_id) begin
        report_test(cur_id);
        cur_id = id;
      end
      case (op)
        4'd0: begin  // One clock with the given inputs
          clear_valid = f_valid[0];
          clear_lines = f_lines[2:0];
          clear_spin  = tetris_score_pkg::spin_kind_t'(f_spin[2:0]);
          new_game    = f_new[0];
          falling     = f_fall[0];
          tick_game   = f_tick[0];
          @(posedge clk);
          #5;
          clear_valid = 1'b0;
          new_game    = 1'b0;
          tick_game   = 1'b0;
          compare_outputs(exp_score, exp_level, exp_total);
        end
        4'd1: begin
          falling = f_fall[0];
          wait_for_drop(exp_ticks);
          compare_outputs(exp_score, exp_level, exp_total);
        end
        4'd2: begin
          hold_no_drop(exp_ticks);
          compare_outputs(exp_score, exp_level, exp_total);
        end
        default: begin
          $display("Unknown operation %0d in stimulus entry %0d", op, i);
          test_errors++;
        end
      endcase
    end
    if (n_steps > 0) begin
      report_test(cur_id);
    end

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog, scaled from the number of entries
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(n_steps + 20) * 100 * 50;
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: src/tetris_scoring.sv
module tetris_scoring #(
  parameter int LINES_PER_LEVEL = 10,
  parameter int SCORE_DIGITS    = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                tick_game,
  input  logic                                new_game,
  input  logic                                clear_valid,
  input  logic [tetris_score_pkg::LINES_W-1:0] clear_lines,
  input  tetris_score_pkg::spin_kind_t         clear_spin,
  input  logic                                falling,
  output logic [4*SCORE_DIGITS-1:0]            score,
  output logic [tetris_pace_pkg::LEVEL_W-1:0]  level,
  output logic [tetris_pace_pkg::TOTAL_W-1:0]  total_lines,
  output logic                                drop_due
);

  logic [tetris_score_pkg::POINTS_W-1:0] line_points;
  logic [tetris_score_pkg::POINTS_W-1:0] spin_points;

  clear_event_if ev ();

  // Event source side
  assign ev.valid = clear_valid;
  assign ev.lines = clear_lines;
  assign ev.spin  = clear_spin;

  assign level = ev.level;

  level_tracker #(
    .LINES_PER_LEVEL(LINES_PER_LEVEL)
  ) level_tracker_inst (
    .clk         (clk),
    .rst         (rst),
    .tick_game   (tick_game),
    .new_game    (new_game),
    .falling     (falling),
    .ev          (ev),
    .total_lines (total_lines),
    .drop_due    (drop_due)
  );

  line_award line_award_inst (
    .ev     (ev),
    .points (line_points)
  );

  spin_award spin_award_inst (
    .ev     (ev),
    .points (spin_points)
  );

  score_accumulator #(
    .SCORE_DIGITS(SCORE_DIGITS)
  ) score_accumulator_inst (
    .clk         (clk),
    .rst         (rst),
    .new_game    (new_game),
    .valid       (ev.valid),
    .lines       (ev.lines),
    .line_points (line_points),
    .spin_points (spin_points),
    .score       (score)
  );

endmodule

// File: src/score_accumulator.sv
module score_accumulator #(
  parameter int SCORE_DIGITS = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 new_game,
  input  logic                                 valid,
  input  logic [tetris_score_pkg::LINES_W-1:0]  lines,
  input  logic [tetris_score_pkg::POINTS_W-1:0] line_points,
  input  logic [tetris_score_pkg::POINTS_W-1:0] spin_points,
  output logic [4*SCORE_DIGITS-1:0]             score
);

  localparam int PW         = tetris_score_pkg::POINTS_W;
  localparam int SUM_DIGITS = 5;   // Covers any 16 bit sum

  logic [PW:0]               sum_wide;
  logic [PW-1:0]             sum;
  logic [4*SUM_DIGITS-1:0]   sum_bcd;
  logic [4*SCORE_DIGITS-1:0] addend;      // Event points as score digits
  logic [4*SCORE_DIGITS-1:0] next_score;
  logic [4:0]                digit_sum;
  logic                      carry;

  assign sum_wide = {1'b0, line_points} + {1'b0, spin_points};
  assign sum      = sum_wide[PW-1:0];

  // ======================================================================
  // Binary to BCD, double dabble
  // ======================================================================

  always_comb begin
    sum_bcd = '0;
    for (int i = PW - 1; i >= 0; i--) begin
      // Pre-correct every digit before the shift
      for (int d = 0; d < SUM_DIGITS; d++) begin
        if (sum_bcd[4*d +: 4] >= 4'd5) begin
          sum_bcd[4*d +: 4] = sum_bcd[4*d +: 4] + 4'd3;
        end
      end
      sum_bcd = {sum_bcd[4*SUM_DIGITS-2:0], sum[i]};
    end
  end

  assign addend = (4 * SCORE_DIGITS)'(sum_bcd);

  // ======================================================================
  // Decimal add into the score
  // ======================================================================

  always_comb begin
    carry      = 1'b0;
    digit_sum  = '0;
    next_score = '0;
    for (int d = 0; d < SCORE_DIGITS; d++) begin
      digit_sum = {1'b0, score[4*d +: 4]} + {1'b0, addend[4*d +: 4]} + {4'd0, carry};
      if (digit_sum >= 5'd10) begin
        next_score[4*d +: 4] = digit_sum[3:0] - 4'd10;  // Modulo 16 gives the right digit
        carry = 1'b1;
      end else begin
        next_score[4*d +: 4] = digit_sum[3:0];
        carry = 1'b0;
      end
    end
    // Carry out of the top digit is dropped, score wraps
  end

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      score <= '0;
    end else if (valid && lines != '0) begin
      score <= next_score;  // Empty locks score nothing, spin or not
    end
  end

  // Both award tables together must stay inside one event's width
  a_sum_fits: assert property (@(posedge clk) disable iff (rst)
    valid |-> !sum_wide[PW]);

  for (genvar g = 0; g < SCORE_DIGITS; g++) begin : g_digit_chk
    a_digit_bcd: assert property (@(posedge clk) disable iff (rst)
      score[4*g +: 4] <= 4'd9);
  end

endmodule

// File: src/spin_award.sv
module spin_award (
  clear_event_if.award                         ev,
  output logic [tetris_score_pkg::POINTS_W-1:0] points
);

  localparam int PW = tetris_score_pkg::POINTS_W;

  logic [tetris_score_pkg::TABLE_W-1:0] entry;
  logic [1:0]                           row;         // Lines minus one
  logic [4:0]                           level_mult;

  assign row        = ev.lines[1:0] - 2'd1;
  assign level_mult = {1'b0, ev.level} + 5'd1;

  // Table by spin kind, entry by line count
  always_comb begin
    entry = '0;
    case (ev.spin)
      tetris_score_pkg::SPIN_T: begin
        if (ev.lines <= 3'd3) begin
          entry = tetris_score_pkg::T_SPIN_POINTS[ev.lines[1:0]];  // Zero lines counts
        end
      end
      tetris_score_pkg::SPIN_T_MINI: begin
        if (ev.lines <= 3'd1) begin
          entry = tetris_score_pkg::T_MINI_POINTS[ev.lines[0]];
        end
      end
      tetris_score_pkg::SPIN_SZ,
      tetris_score_pkg::SPIN_JL: begin
        if (ev.lines >= 3'd1 && ev.lines <= 3'd3) begin
          entry = tetris_score_pkg::SZJL_POINTS[row];
        end
      end
      tetris_score_pkg::SPIN_I: begin
        if (ev.lines >= 3'd1 && ev.lines <= 3'd4) begin
          entry = tetris_score_pkg::I_SPIN_POINTS[row];
        end
      end
      default: entry = '0;  // No spin
    endcase
  end

  assign points = ev.valid ? PW'(entry) * PW'(level_mult) : '0;

endmodule

// File: src/line_award.sv
module line_award (
  clear_event_if.award                         ev,
  output logic [tetris_score_pkg::POINTS_W-1:0] points
);

  localparam int PW = tetris_score_pkg::POINTS_W;

  logic [tetris_score_pkg::TABLE_W-1:0] base;
  logic [1:0]                           row;         // Table row, 0 is a single
  logic [4:0]                           level_mult;  // 1 to 16
  logic [PW-1:0]                        base_total;
  logic [PW-1:0]                        streak_raw;
  logic [PW-1:0]                        streak_bonus;

  assign row        = ev.lines[1:0] - 2'd1;
  assign level_mult = {1'b0, ev.level} + 5'd1;

  always_comb begin
    base = '0;
    if (ev.lines >= 3'd1 && ev.lines <= 3'd4) begin
      base = tetris_score_pkg::BASE_POINTS[row];
    end
    base_total = PW'(base) * PW'(level_mult);
  end

  // Streak bonus, flat and not scaled by level
  always_comb begin
    streak_raw   = PW'(ev.streak) * PW'(tetris_score_pkg::STREAK_STEP);
    streak_bonus = '0;
    if (ev.lines != '0 && ev.streak != '0) begin
      if (streak_raw > PW'(tetris_score_pkg::STREAK_CAP)) begin
        streak_bonus = PW'(tetris_score_pkg::STREAK_CAP);
      end else begin
        streak_bonus = streak_raw;
      end
    end
  end

  assign points = ev.valid ? base_total + streak_bonus : '0;  // Idle gives nothing

endmodule

// File: src/level_tracker.sv
module level_tracker #(
  parameter int LINES_PER_LEVEL = 10
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                tick_game,
  input  logic                                new_game,
  input  logic                                falling,
  clear_event_if.tracker                      ev,
  output logic [tetris_pace_pkg::TOTAL_W-1:0] total_lines,
  output logic                                drop_due
);

  localparam int TW = tetris_pace_pkg::TOTAL_W;
  localparam int LW = tetris_pace_pkg::LEVEL_W;
  localparam int GW = tetris_pace_pkg::GRAVITY_W;

  logic [TW:0]   total_sum;    // One spare bit for saturation
  logic [TW-1:0] level_raw;
  logic [GW-1:0] drop_count;
  logic [GW-1:0] drop_period;

  // ======================================================================
  // Line total, level and streak
  // ======================================================================

  assign total_sum = {1'b0, total_lines} + (TW + 1)'(ev.lines);

  assign level_raw = TW'(total_lines / LINES_PER_LEVEL);
  assign ev.level  = (level_raw > TW'(tetris_pace_pkg::MAX_LEVEL)) ?
                     LW'(tetris_pace_pkg::MAX_LEVEL) : level_raw[LW-1:0];

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      total_lines <= '0;
      ev.streak   <= '0;
    end else if (ev.valid) begin
      if (ev.lines != '0) begin
        total_lines <= total_sum[TW] ? '1 : total_sum[TW-1:0];  // Stick at 255
        if (ev.streak != '1) begin
          ev.streak <= ev.streak + 1'b1;
        end
      end else begin
        ev.streak <= '0;  // Empty lock breaks the streak
      end
    end
  end

  // ======================================================================
  // Gravity timer
  // ======================================================================

  assign drop_period = tetris_pace_pkg::GRAVITY_FRAMES[ev.level];

  always_ff @(posedge clk) begin
    if (rst || new_game) begin
      drop_count <= '0;
      drop_due   <= 1'b0;
    end else begin
      drop_due <= 1'b0;
      if (!falling) begin
        drop_count <= '0;  // Nothing to drop
      end else if (tick_game) begin
        // Greater-or-equal covers a level-up that shortens the period
        if (drop_count >= drop_period) begin
          drop_count <= '0;
          drop_due   <= 1'b1;
        end else begin
          drop_count <= drop_count + 1'b1;
        end
      end
    end
  end

  // Shortest period is two ticks, so pulses never touch
  a_drop_single: assert property (@(posedge clk) disable iff (rst)
    drop_due |=> !drop_due);

endmodule

// File: src/clear_event_if.sv
// One lock event together with the level and streak as they stood before it
interface clear_event_if;

  logic                                  valid;   // One-cycle lock strobe
  logic [tetris_score_pkg::LINES_W-1:0]  lines;
  tetris_score_pkg::spin_kind_t          spin;
  logic [tetris_pace_pkg::LEVEL_W-1:0]   level;   // Pre-event level
  logic [tetris_pace_pkg::STREAK_W-1:0]  streak;  // Pre-event streak

  // Level and streak owner
  modport tracker (input valid, lines, output level, streak);

  // Point calculators
  modport award (input valid, lines, spin, level, streak);

  // Event producer
  modport source (output valid, lines, spin);

endinterface

// File: src/tetris_pace_pkg.sv
package tetris_pace_pkg;

  localparam int LEVEL_W   = 4;   // Level 0 to 15
  localparam int MAX_LEVEL = 15;
  localparam int TOTAL_W   = 8;   // Line total, saturates at 255
  localparam int STREAK_W  = 4;   // Streak, saturates at 15
  localparam int GRAVITY_W = 6;   // Ticks per drop

  // Game ticks between drops, one entry per level
  localparam logic [GRAVITY_W-1:0] GRAVITY_FRAMES [MAX_LEVEL+1] = '{
    6'd40,
    6'd37,
    6'd34,
    6'd30,
    6'd26,
    6'd21,
    6'd15,
    6'd12,
    6'd8,
    6'd6,
    6'd5,
    6'd5,
    6'd5,
    6'd4,
    6'd3,
    6'd2   // Top speed
  };

endpackage

// File: src/tetris_score_pkg.sv
package tetris_score_pkg;

  // Spin kind that arrives with each lock event
  typedef enum logic [2:0] {
    SPIN_NONE,
    SPIN_T,
    SPIN_T_MINI,
    SPIN_SZ,
    SPIN_JL,
    SPIN_I
  } spin_kind_t;

  localparam int LINES_W  = 3;   // Cleared lines, 0 to 4
  localparam int POINTS_W = 16;  // Points of one event
  localparam int TABLE_W  = 12;  // Width of every point table entry

  // NES base values, entry 0 is a single
  localparam logic [TABLE_W-1:0] BASE_POINTS [4] = '{12'd40, 12'd100, 12'd300, 12'd1200};

  // Streak bonus per consecutive clear
  localparam int STREAK_STEP = 100;
  localparam int STREAK_CAP  = 500;

  // T-spin, entry n is n lines
  localparam logic [TABLE_W-1:0] T_SPIN_POINTS [4] = '{12'd400, 12'd800, 12'd1200, 12'd1600};

  // T-spin mini, zero or one line only
  localparam logic [TABLE_W-1:0] T_MINI_POINTS [2] = '{12'd100, 12'd200};

  // S, Z, J and L spins share one table, entry 0 is a single
  localparam logic [TABLE_W-1:0] SZJL_POINTS [3] = '{12'd400, 12'd800, 12'd1200};

  // I-spin, entry 0 is a single
  // No triple is possible, so that slot stays empty
  localparam logic [TABLE_W-1:0] I_SPIN_POINTS [4] = '{12'd400, 12'd800, 12'd0, 12'd1600};

endpackage
